// File: list.f
+incdir+common
common/beeb_pkg.sv
design/clock_enables.sv
rom_map/rom_slot_map.sv
design/sd_route.sv
joystick/mouse_axis.sv
joystick/joy_route.sv
design/beeb_glue_top.sv
sim/tb_clk_gen.sv
sim/tb_beeb_glue.sv

// File: sim/tb_beeb_glue.sv
/*
 * testbench for the board glue top level
 * random stimulus from a fixed seed, expected values from a local model
 * inputs change on the rising edge, outputs are sampled on the falling edge
 */
`timescale 1ns/1ps

module tb_beeb_glue
	import beeb_pkg::*;
;

	localparam int ACT_HOLD = 50;
	localparam int ROM_N    = 150;
	localparam int SD_N     = 24;
	localparam int MOUSE_N  = 200;
	localparam int JOY_N    = 200;
	// tests take about 1.5k cycles, generous margin on top
	localparam int MAX_CYCLES = 20000;

	logic       clk_sys;
	logic       rst_n;
	logic       reset_req;
	logic       ce_48;
	logic       ce_32;
	logic       ce_24;
	logic       model_sel;
	fs_sel_t    fs_sel;
	cpu_addr_t  cpu_addr;
	logic [7:0] rom_dout;
	rom_addr_t  rom_addr;
	logic [7:0] rom_data;
	logic       img_mounted;
	logic       img_present;
	logic       spi_sck;
	logic       spi_mosi;
	logic       spi_ss;
	logic       vsd_miso;
	logic       sd_miso;
	logic       core_miso;
	logic       vsd_ss;
	logic       sd_cs;
	logic       sd_sck;
	logic       sd_mosi;
	logic       vsd_sel;
	logic       sd_act;
	logic       mouse_stb;
	logic [8:0] mouse_dx;
	logic [8:0] mouse_dy;
	logic [1:0] mouse_btn;
	logic       joy1_active;
	logic       mouse_off;
	stick_t     joy1_x;
	stick_t     joy1_y;
	stick_t     joy2_x;
	stick_t     joy2_y;
	logic       joy1_fire;
	logic       joy2_fire;
	logic       swap;
	core_axis_t joystick1_x;
	core_axis_t joystick1_y;
	core_axis_t joystick2_x;
	core_axis_t joystick2_y;
	logic       joystick1_fire;
	logic       joystick2_fire;

	// reference model state
	int   m_x;
	int   m_y;
	logic m_emu;
	logic m_sel;

	// bookkeeping
	int cycle_cnt;
	int n_checks;
	int n_errors;
	int n_tests;
	int n_failed;
	int err_base;

	tb_clk_gen u_clk_gen (
		.reset_req (reset_req),
		.clk_sys   (clk_sys),
		.rst_n     (rst_n)
	);

	beeb_glue_top #(
		.ACT_HOLD (ACT_HOLD)
	) UUT (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.ce_48          (ce_48),
		.ce_32          (ce_32),
		.ce_24          (ce_24),
		.model_sel      (model_sel),
		.fs_sel         (fs_sel),
		.cpu_addr       (cpu_addr),
		.rom_dout       (rom_dout),
		.rom_addr       (rom_addr),
		.rom_data       (rom_data),
		.img_mounted    (img_mounted),
		.img_present    (img_present),
		.spi_sck        (spi_sck),
		.spi_mosi       (spi_mosi),
		.spi_ss         (spi_ss),
		.vsd_miso       (vsd_miso),
		.sd_miso        (sd_miso),
		.core_miso      (core_miso),
		.vsd_ss         (vsd_ss),
		.sd_cs          (sd_cs),
		.sd_sck         (sd_sck),
		.sd_mosi        (sd_mosi),
		.vsd_sel        (vsd_sel),
		.sd_act         (sd_act),
		.mouse_stb      (mouse_stb),
		.mouse_dx       (mouse_dx),
		.mouse_dy       (mouse_dy),
		.mouse_btn      (mouse_btn),
		.joy1_active    (joy1_active),
		.mouse_off      (mouse_off),
		.joy1_x         (joy1_x),
		.joy1_y         (joy1_y),
		.joy2_x         (joy2_x),
		.joy2_y         (joy2_y),
		.joy1_fire      (joy1_fire),
		.joy2_fire      (joy2_fire),
		.swap           (swap),
		.joystick1_x    (joystick1_x),
		.joystick1_y    (joystick1_y),
		.joystick2_x    (joystick2_x),
		.joystick2_y    (joystick2_y),
		.joystick1_fire (joystick1_fire),
		.joystick2_fire (joystick2_fire)
	);

	// ==================================================
	// reference model
	// ==================================================

	// bank to slot, straight from the slot table
	function automatic logic [3:0] exp_slot(input logic m128, input logic [3:0] bank,
			input logic [2:0] fs);
		logic v1;
		v1 = (fs == 3'd0) || (fs == 3'd3);
		if (!m128) begin
			case (bank)
				4'd3:    return 4'd4;
				4'd4:    return 4'd0;
				4'd8:    return v1 ? 4'd1 : 4'd14;
				4'd14:   return 4'd2;
				4'd15:   return 4'd3;
				default: return 4'd0;
			endcase
		end
		if (bank == 4'd3)
			return v1 ? 4'd5 : 4'd15;
		if (bank == 4'd4)
			return 4'd6;
		// master banks 9..15 land on slots 7..13
		if (bank >= 4'd9)
			return bank - 4'd2;
		return 4'd0;
	endfunction

	function automatic logic [7:0] exp_data(input logic m128, input logic [3:0] bank,
			input logic [2:0] fs, input logic [7:0] dout);
		logic mapped;
		logic dfs_on;
		logic mmfs_on;
		dfs_on  = (fs >= 3'd2);
		mmfs_on = (fs != 3'd2);
		if (!m128)
			mapped = (bank == 4'd3) || (bank == 4'd4) || (bank == 4'd8) || (bank >= 4'd14);
		else
			mapped = (bank == 4'd3) || (bank == 4'd4) || (bank >= 4'd9);
		if (!mapped)
			return 8'h00;
		// dfs images
		if ((!m128 && bank == 4'd3) || (m128 && bank == 4'd9))
			return dfs_on ? dout : 8'h00;
		// mmfs images
		if ((!m128 && bank == 4'd8) || (m128 && bank == 4'd3))
			return mmfs_on ? dout : 8'h00;
		return dout;
	endfunction

	// per-packet move limited to +-10
	function automatic int step_limit(input logic [8:0] raw);
		int d;
		d = $signed(raw);
		if (d > 10)
			d = 10;
		else if (d < -10)
			d = -10;
		return d;
	endfunction

	function automatic int sat8(input int v);
		if (v > 127)
			return 127;
		if (v < -128)
			return -128;
		return v;
	endfunction

	// flip top bit, mirror against 255, widen with the upper nibble
	function automatic logic [11:0] scale_axis(input logic [7:0] v);
		int u;
		u = 255 - ((int'(v) + 128) % 256);
		return {u[7:0], u[7:4]};
	endfunction

	// ==================================================
	// checking and reporting
	// ==================================================

	task automatic check_equal(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("error: t=%0t %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic start_test();
		err_base = n_errors;
	endtask

	task automatic report_test(input string name);
		n_tests++;
		if (n_errors == err_base) begin
			$display("test %s: ok", name);
		end else begin
			n_failed++;
			$display("test %s: failed with %0d errors", name, n_errors - err_base);
		end
	endtask

	// ==================================================
	// helpers
	// ==================================================

	task automatic apply_reset(input logic model);
		@(posedge clk_sys);
		model_sel <= model;
		reset_req <= 1'b1;
		@(posedge clk_sys);
		reset_req <= 1'b0;
		@(negedge clk_sys);
		while (!rst_n)
			@(negedge clk_sys);
	endtask

	task automatic check_sd_lines();
		logic e_miso;
		logic e_vss;
		logic e_cs;
		logic e_sck;
		logic e_mosi;
		e_miso = m_sel ? vsd_miso : sd_miso;
		e_vss  = m_sel ? spi_ss : 1'b1;
		e_cs   = m_sel ? 1'b1 : spi_ss;
		e_sck  = m_sel ? 1'b0 : spi_sck;
		e_mosi = m_sel ? 1'b0 : spi_mosi;
		check_equal("vsd_sel", vsd_sel, m_sel);
		check_equal("core_miso", core_miso, e_miso);
		check_equal("vsd_ss", vsd_ss, e_vss);
		check_equal("sd_cs", sd_cs, e_cs);
		check_equal("sd_sck", sd_sck, e_sck);
		check_equal("sd_mosi", sd_mosi, e_mosi);
	endtask

	// k counts edges from the one that changed a line
	// one edge to see the change, hold count, one edge to register sd_act
	task automatic watch_activity(input logic from_idle);
		int k;
		for (k = 0; k <= ACT_HOLD + 4; k++) begin
			@(negedge clk_sys);
			if (k >= 2)
				check_equal("sd_act", sd_act, k <= ACT_HOLD + 1);
			else if (k == 1 && from_idle)
				check_equal("sd_act", sd_act, 1'b0);
		end
	endtask

	task automatic check_joysticks();
		logic [7:0] ax;
		logic [7:0] ay;
		logic       af;
		logic       f1;
		logic       f2;
		ax = m_emu ? 8'(m_x) : joy1_x;
		ay = m_emu ? 8'(m_y) : joy1_y;
		af = m_emu ? (mouse_btn != 2'b00) : joy1_fire;
		// fire outputs are active low
		f1 = swap ? !joy2_fire : !af;
		f2 = swap ? !af : !joy2_fire;
		check_equal("joystick1_x", joystick1_x, swap ? scale_axis(joy2_x) : scale_axis(ax));
		check_equal("joystick1_y", joystick1_y, swap ? scale_axis(joy2_y) : scale_axis(ay));
		check_equal("joystick2_x", joystick2_x, swap ? scale_axis(ax) : scale_axis(joy2_x));
		check_equal("joystick2_y", joystick2_y, swap ? scale_axis(ay) : scale_axis(joy2_y));
		check_equal("joystick1_fire", joystick1_fire, f1);
		check_equal("joystick2_fire", joystick2_fire, f2);
	endtask

	// one mouse packet or idle cycle plus fresh stick values, then check
	task automatic mouse_joy_step(input int dx, input int dy, input logic pkt,
			input logic clr, input logic swp);
		@(posedge clk_sys);
		mouse_dx  <= 9'(dx);
		mouse_dy  <= 9'(dy);
		mouse_btn <= 2'($urandom);
		if (pkt)
			mouse_stb <= !mouse_stb;
		if (clr) begin
			if ($urandom_range(1) == 1)
				joy1_active <= 1'b1;
			else
				mouse_off <= 1'b1;
		end
		joy1_x    <= 8'($urandom);
		joy1_y    <= 8'($urandom);
		joy2_x    <= 8'($urandom);
		joy2_y    <= 8'($urandom);
		joy1_fire <= 1'($urandom);
		joy2_fire <= 1'($urandom);
		swap      <= swp;
		@(posedge clk_sys);
		joy1_active <= 1'b0;
		mouse_off   <= 1'b0;
		@(negedge clk_sys);
		// clear beats a packet on the same edge
		if (clr) begin
			m_x   = 0;
			m_y   = 0;
			m_emu = 1'b0;
		end else if (pkt) begin
			m_x   = sat8(m_x + step_limit(mouse_dx));
			m_y   = sat8(m_y - step_limit(mouse_dy));
			m_emu = 1'b1;
		end
		check_joysticks();
	endtask

	// ==================================================
	// tests
	// ==================================================

	task automatic test_clock_enables();
		int k;
		start_test();
		@(negedge clk_sys);
		while (!rst_n) begin
			check_equal("ce_48", ce_48, 1'b0);
			check_equal("ce_32", ce_32, 1'b0);
			check_equal("ce_24", ce_24, 1'b0);
			@(negedge clk_sys);
		end
		// first edge out of reset fires all three
		for (k = 1; k <= 48; k++) begin
			@(negedge clk_sys);
			check_equal("ce_48", ce_48, ((k - 1) % 2) == 0);
			check_equal("ce_32", ce_32, ((k - 1) % 3) == 0);
			check_equal("ce_24", ce_24, ((k - 1) % 4) == 0);
		end
		report_test("clock_enables");
	endtask

	task automatic test_rom_map();
		int         i;
		int         m;
		logic [2:0] fs;
		logic [17:0] addr;
		logic [7:0] dout;
		logic [3:0] slot;
		start_test();
		for (m = 0; m < 2; m++) begin
			apply_reset(1'(m));
			for (i = 0; i < ROM_N; i++) begin
				fs   = 3'($urandom_range(4));
				addr = 18'($urandom);
				dout = 8'($urandom);
				@(posedge clk_sys);
				fs_sel    <= fs;
				cpu_addr  <= addr;
				rom_dout  <= dout;
				// model is held from reset, wiggling the pin must not matter
				model_sel <= 1'($urandom);
				@(negedge clk_sys);
				slot = exp_slot(1'(m), addr[17:14], fs);
				check_equal("rom_addr", rom_addr, {slot, addr[13:0]});
				check_equal("rom_data", rom_data, exp_data(1'(m), addr[17:14], fs, dout));
			end
		end
		report_test("rom_slot_map");
	endtask

	task automatic test_sd_route();
		int   i;
		logic p;
		logic mnt;
		start_test();
		// bus untouched since reset
		@(negedge clk_sys);
		check_equal("sd_act", sd_act, 1'b0);
		check_equal("vsd_sel", vsd_sel, m_sel);
		for (i = 0; i < SD_N; i++) begin
			p   = 1'($urandom);
			mnt = ($urandom_range(3) != 0);
			@(posedge clk_sys);
			img_present <= p;
			img_mounted <= mnt;
			spi_sck     <= 1'($urandom);
			spi_mosi    <= 1'($urandom);
			spi_ss      <= 1'($urandom);
			vsd_miso    <= 1'($urandom);
			sd_miso     <= 1'($urandom);
			@(posedge clk_sys);
			img_mounted <= 1'b0;
			@(negedge clk_sys);
			if (mnt)
				m_sel = p;
			check_sd_lines();
		end
		// last bus change on mosi, then let the stretch run out
		@(posedge clk_sys);
		spi_mosi <= !spi_mosi;
		watch_activity(1'b0);
		// a miso edge from the selected card starts it again
		@(posedge clk_sys);
		if (m_sel)
			vsd_miso <= !vsd_miso;
		else
			sd_miso <= !sd_miso;
		watch_activity(1'b1);
		report_test("sd_route");
	endtask

	task automatic test_mouse();
		int i;
		int dir;
		int mag;
		int dx;
		int dy;
		start_test();
		for (i = 0; i < MOUSE_N; i++) begin
			// runs of 50 packets push towards one limit then the other
			dir = ((i / 50) % 2 == 0) ? 1 : -1;
			if ($urandom_range(7) == 0) begin
				dx = int'($urandom_range(511)) - 256;
				dy = int'($urandom_range(511)) - 256;
			end else begin
				mag = int'($urandom_range(14));
				dx  = dir * mag;
				mag = int'($urandom_range(14));
				dy  = -dir * mag;
			end
			mouse_joy_step(dx, dy, 1'b1, (i % 100) == 99, 1'b0);
		end
		report_test("mouse_axis");
	endtask

	task automatic test_joy();
		int i;
		int dx;
		int dy;
		start_test();
		for (i = 0; i < JOY_N; i++) begin
			dx = int'($urandom_range(40)) - 20;
			dy = int'($urandom_range(40)) - 20;
			// emu turns on with packets and off with clears
			mouse_joy_step(dx, dy, 1'($urandom), $urandom_range(3) == 0, 1'($urandom));
		end
		report_test("joy_route");
	endtask

	// ==================================================
	// run control
	// ==================================================

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < MAX_CYCLES) begin
			@(posedge clk_sys);
			cycle_cnt++;
		end
		$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		void'($urandom(21841));
		n_checks    = 0;
		n_errors    = 0;
		n_tests     = 0;
		n_failed    = 0;
		err_base    = 0;
		m_x         = 0;
		m_y         = 0;
		m_emu       = 1'b0;
		m_sel       = 1'b0;
		reset_req   = 1'b0;
		model_sel   = 1'b0;
		fs_sel      = 3'd0;
		cpu_addr    = '0;
		rom_dout    = 8'h00;
		img_mounted = 1'b0;
		img_present = 1'b0;
		spi_sck     = 1'b0;
		spi_mosi    = 1'b1;
		spi_ss      = 1'b1;
		vsd_miso    = 1'b1;
		sd_miso     = 1'b1;
		mouse_stb   = 1'b0;
		mouse_dx    = '0;
		mouse_dy    = '0;
		mouse_btn   = 2'b00;
		joy1_active = 1'b0;
		mouse_off   = 1'b0;
		joy1_x      = 8'h80;
		joy1_y      = 8'h80;
		joy2_x      = 8'h80;
		joy2_y      = 8'h80;
		joy1_fire   = 1'b0;
		joy2_fire   = 1'b0;
		swap        = 1'b0;

		test_clock_enables();
		test_rom_map();
		test_sd_route();
		test_mouse();
		test_joy();

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			n_tests, n_failed, n_checks, n_errors);
		if (n_errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: sim/tb_clk_gen.sv
/*
 * testbench clock and reset source, 8 ns period
 * reset is held low for 8 cycles at power-on and again on each reset_req
 */
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int PERIOD     = 8,
	parameter int RST_CYCLES = 8
) (
	input  logic reset_req,
	output logic clk_sys,
	output logic rst_n
);

	int rst_cnt;

	initial begin
		clk_sys = 1'b0;
		rst_n   = 1'b0;
		rst_cnt = 0;
	end

	always #(PERIOD / 2) clk_sys = ~clk_sys;

	// synchronous release, dut sees RST_CYCLES low edges
	always @(posedge clk_sys) begin
		if (reset_req) begin
			rst_n   <= 1'b0;
			rst_cnt <= 0;
		end else if (rst_cnt < RST_CYCLES - 1) begin
			rst_cnt <= rst_cnt + 1;
		end else begin
			rst_n <= 1'b1;
		end
	end

endmodule

// File: design/beeb_glue_top.sv
/*
 * board glue top level around the BBC Micro / Master core
 * clock enables, ROM slot map, SD routing and analog joystick paths
 */
`timescale 1ns/1ps
`include "beeb_cfg.svh"

module beeb_glue_top
	import beeb_pkg::*;
#(
	parameter int unsigned ACT_HOLD = `SD_ACT_HOLD_DEFAULT
) (
	input  logic       clk_sys,
	input  logic       rst_n,
	// clock enables
	output logic       ce_48,
	output logic       ce_32,
	output logic       ce_24,
	// rom
	input  logic       model_sel,
	input  fs_sel_t    fs_sel,
	input  cpu_addr_t  cpu_addr,
	input  logic [7:0] rom_dout,
	output rom_addr_t  rom_addr,
	output logic [7:0] rom_data,
	// sd
	input  logic       img_mounted,
	input  logic       img_present,
	input  logic       spi_sck,
	input  logic       spi_mosi,
	input  logic       spi_ss,
	input  logic       vsd_miso,
	input  logic       sd_miso,
	output logic       core_miso,
	output logic       vsd_ss,
	output logic       sd_cs,
	output logic       sd_sck,
	output logic       sd_mosi,
	output logic       vsd_sel,
	output logic       sd_act,
	// mouse
	input  logic       mouse_stb,
	input  logic [8:0] mouse_dx,
	input  logic [8:0] mouse_dy,
	input  logic [1:0] mouse_btn,
	input  logic       joy1_active,
	input  logic       mouse_off,
	// sticks
	input  stick_t     joy1_x,
	input  stick_t     joy1_y,
	input  stick_t     joy2_x,
	input  stick_t     joy2_y,
	input  logic       joy1_fire,
	input  logic       joy2_fire,
	input  logic       swap,
	output core_axis_t joystick1_x,
	output core_axis_t joystick1_y,
	output core_axis_t joystick2_x,
	output core_axis_t joystick2_y,
	output logic       joystick1_fire,
	output logic       joystick2_fire
);

	// mouse to stick routing
	axis_t mx;
	axis_t my;
	logic  emu;
	logic  mouse_fire;

	clock_enables u_clock_enables (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.ce_48   (ce_48),
		.ce_32   (ce_32),
		.ce_24   (ce_24)
	);

	rom_slot_map u_rom_slot_map (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.model_sel (model_sel),
		.fs_sel    (fs_sel),
		.cpu_addr  (cpu_addr),
		.rom_dout  (rom_dout),
		.rom_addr  (rom_addr),
		.rom_data  (rom_data)
	);

	sd_route #(
		.ACT_HOLD (ACT_HOLD)
	) u_sd_route (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.img_mounted (img_mounted),
		.img_present (img_present),
		.spi_sck     (spi_sck),
		.spi_mosi    (spi_mosi),
		.spi_ss      (spi_ss),
		.vsd_miso    (vsd_miso),
		.sd_miso     (sd_miso),
		.core_miso   (core_miso),
		.vsd_ss      (vsd_ss),
		.sd_cs       (sd_cs),
		.sd_sck      (sd_sck),
		.sd_mosi     (sd_mosi),
		.vsd_sel     (vsd_sel),
		.sd_act      (sd_act)
	);

	mouse_axis u_mouse_axis (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.mouse_stb   (mouse_stb),
		.mouse_dx    (mouse_dx),
		.mouse_dy    (mouse_dy),
		.mouse_btn   (mouse_btn),
		.joy1_active (joy1_active),
		.mouse_off   (mouse_off),
		.mx          (mx),
		.my          (my),
		.emu         (emu),
		.mouse_fire  (mouse_fire)
	);

	joy_route u_joy_route (
		.mx             (mx),
		.my             (my),
		.emu            (emu),
		.mouse_fire     (mouse_fire),
		.joy1_x         (joy1_x),
		.joy1_y         (joy1_y),
		.joy2_x         (joy2_x),
		.joy2_y         (joy2_y),
		.joy1_fire      (joy1_fire),
		.joy2_fire      (joy2_fire),
		.swap           (swap),
		.joystick1_x    (joystick1_x),
		.joystick1_y    (joystick1_y),
		.joystick2_x    (joystick2_x),
		.joystick2_y    (joystick2_y),
		.joystick1_fire (joystick1_fire),
		.joystick2_fire (joystick2_fire)
	);

endmodule

// File: joystick/joy_route.sv
/*
 * analog stick routing into the core's 12-bit ADC inputs
 * stick A is the mouse when emulating, else stick 1; swap exchanges ports
 */
`timescale 1ns/1ps

module joy_route
	import beeb_pkg::*;
(
	input  axis_t      mx,
	input  axis_t      my,
	input  logic       emu,
	input  logic       mouse_fire,
	input  stick_t     joy1_x,
	input  stick_t     joy1_y,
	input  stick_t     joy2_x,
	input  stick_t     joy2_y,
	input  logic       joy1_fire,
	input  logic       joy2_fire,
	input  logic       swap,
	output core_axis_t joystick1_x,
	output core_axis_t joystick1_y,
	output core_axis_t joystick2_x,
	output core_axis_t joystick2_y,
	output logic       joystick1_fire,
	output logic       joystick2_fire
);

	stick_t     ax;
	stick_t     ay;
	logic       af;
	core_axis_t a_x;
	core_axis_t a_y;
	core_axis_t b_x;
	core_axis_t b_y;

	// signed centre-zero to unsigned, flipped to the beeb's direction,
	// then widened by repeating the top nibble
	function automatic core_axis_t rebase(input stick_t v);
		stick_t r;
		r = 8'hFF - {~v[7], v[6:0]};
		rebase = {r, r[7:4]};
	endfunction

	// stick A source
	assign ax = emu ? stick_t'(mx[7:0]) : joy1_x;
	assign ay = emu ? stick_t'(my[7:0]) : joy1_y;
	assign af = emu ? mouse_fire : joy1_fire;

	assign a_x = rebase(ax);
	assign a_y = rebase(ay);
	assign b_x = rebase(joy2_x);
	assign b_y = rebase(joy2_y);

	// ==================================================
	// port assignment, fire is active low at the core
	// ==================================================

	assign joystick1_x    = swap ? b_x : a_x;
	assign joystick1_y    = swap ? b_y : a_y;
	assign joystick1_fire = swap ? ~joy2_fire : ~af;

	assign joystick2_x    = swap ? a_x : b_x;
	assign joystick2_y    = swap ? a_y : b_y;
	assign joystick2_fire = swap ? ~af : ~joy2_fire;

endmodule

// File: joystick/mouse_axis.sv
/*
 * mouse-as-joystick: integrates packet deltas into a clamped X/Y position
 * a toggle on mouse_stb marks a new packet; a real stick or menu off clears it
 */
`timescale 1ns/1ps
`include "beeb_cfg.svh"

module mouse_axis
	import beeb_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       mouse_stb,
	input  logic [8:0] mouse_dx,
	input  logic [8:0] mouse_dy,
	input  logic [1:0] mouse_btn,
	input  logic       joy1_active,
	input  logic       mouse_off,
	output axis_t      mx,
	output axis_t      my,
	output logic       emu,
	output logic       mouse_fire
);

	logic  old_stb;
	logic  stb_toggle;
	logic  clear;
	axis_t step_x;
	axis_t step_y;
	axis_t sum_x;
	axis_t sum_y;

	// limit one packet's move so a fast swipe doesn't jump across
	function automatic axis_t clamp_step(input logic [8:0] raw);
		axis_t d;
		d = axis_t'(raw);
		if (d > `MOUSE_STEP_MAX)
			clamp_step = axis_t'(`MOUSE_STEP_MAX);
		else if (d < -`MOUSE_STEP_MAX)
			clamp_step = axis_t'(-`MOUSE_STEP_MAX);
		else
			clamp_step = d;
	endfunction

	// pin the position to the 8-bit signed range
	function automatic axis_t saturate(input axis_t v);
		if (v < `AXIS_MIN)
			saturate = axis_t'(`AXIS_MIN);
		else if (v > `AXIS_MAX)
			saturate = axis_t'(`AXIS_MAX);
		else
			saturate = v;
	endfunction

	assign step_x = clamp_step(mouse_dx);
	assign step_y = clamp_step(mouse_dy);

	// screen y runs opposite to mouse y
	assign sum_x = mx + step_x;
	assign sum_y = my - step_y;

	assign stb_toggle = (old_stb != mouse_stb);
	assign clear      = joy1_active | mouse_off;
	assign mouse_fire = |mouse_btn;

	// ==================================================
	// position registers
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			// follow the strobe so reset release is not a packet
			old_stb <= mouse_stb;
			mx      <= '0;
			my      <= '0;
			emu     <= 1'b0;
		end else begin
			old_stb <= mouse_stb;
			if (clear) begin
				mx  <= '0;
				my  <= '0;
				emu <= 1'b0;
			end else if (stb_toggle) begin
				mx  <= saturate(sum_x);
				my  <= saturate(sum_y);
				emu <= 1'b1;
			end
		end
	end

	// joy_route only forwards the low byte, so the range must hold
	a_axis_range : assert property (@(posedge clk_sys) disable iff (!rst_n)
		(mx >= `AXIS_MIN) && (mx <= `AXIS_MAX) &&
		(my >= `AXIS_MIN) && (my <= `AXIS_MAX))
		else $error("mouse axis out of range: mx %0d my %0d", mx, my);

endmodule

// File: design/sd_route.sv
/*
 * routes the core's SPI master to the virtual card or the physical SD slot
 * a mounted image takes over; sd_act stretches bus edges for a disk LED
 */
`timescale 1ns/1ps
`include "beeb_cfg.svh"

module sd_route #(
	parameter int unsigned ACT_HOLD = `SD_ACT_HOLD_DEFAULT
) (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic img_mounted,
	input  logic img_present,
	input  logic spi_sck,
	input  logic spi_mosi,
	input  logic spi_ss,
	input  logic vsd_miso,
	input  logic sd_miso,
	output logic core_miso,
	output logic vsd_ss,
	output logic sd_cs,
	output logic sd_sck,
	output logic sd_mosi,
	output logic vsd_sel,
	output logic sd_act
);

	localparam int CNT_W = $clog2(ACT_HOLD + 1);

	logic             old_mosi;
	logic             old_miso;
	logic             bus_edge;
	logic [CNT_W-1:0] hold_cnt;

	// card select follows the size of the last mount
	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			vsd_sel <= 1'b0;
		else if (img_mounted)
			vsd_sel <= img_present;
	end

	// ==================================================
	// spi steering
	// ==================================================

	assign core_miso = vsd_sel ? vsd_miso : sd_miso;

	// virtual card only sees ss while selected
	assign vsd_ss  = spi_ss | ~vsd_sel;

	// park the physical card while the image is in use
	assign sd_cs   = spi_ss | vsd_sel;
	assign sd_sck  = spi_sck & ~vsd_sel;
	assign sd_mosi = spi_mosi & ~vsd_sel;

	// ==================================================
	// activity stretch
	// ==================================================

	assign bus_edge = (old_mosi ^ spi_mosi) | (old_miso ^ core_miso);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			// track the lines so the first cycle sees no false edge
			old_mosi <= spi_mosi;
			old_miso <= core_miso;
			hold_cnt <= CNT_W'(ACT_HOLD);
			sd_act   <= 1'b0;
		end else begin
			old_mosi <= spi_mosi;
			old_miso <= core_miso;
			sd_act   <= (hold_cnt < CNT_W'(ACT_HOLD));
			if (bus_edge)
				hold_cnt <= '0;
			else if (hold_cnt < CNT_W'(ACT_HOLD))
				hold_cnt <= hold_cnt + 1'b1;
		end
	end

endmodule

// File: rom_map/rom_slot_map.sv
/*
 * sideways ROM bank to physical slot mapper for model B and Master
 * model is sampled while reset is held; address and data paths are combinational
 */
`timescale 1ns/1ps
`include "beeb_cfg.svh"

module rom_slot_map
	import beeb_pkg::*;
(
	input  logic      clk_sys,
	input  logic      rst_n,
	input  logic      model_sel,
	input  fs_sel_t   fs_sel,
	input  cpu_addr_t cpu_addr,
	input  logic [7:0] rom_dout,
	output rom_addr_t rom_addr,
	output logic [7:0] rom_data
);

	logic  m128;
	logic  mmfsv1;
	logic  mmfsv2;
	logic  dfs;
	bank_t bank;
	slot_t slot;

	// model only changes across a reset
	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			m128 <= model_sel;
	end

	// filing system enables
	assign mmfsv1 = (fs_sel == 3'd0) || (fs_sel == 3'd3);
	assign mmfsv2 = (fs_sel == 3'd1) || (fs_sel == 3'd4);
	assign dfs    = (fs_sel >= 3'd2);

	assign bank = cpu_addr[17:14];

	// ==================================================
	// bank to slot
	// ==================================================

	always_comb begin
		case ({m128, bank})
			// model B
			5'b0_0011: slot = slot_t'(`SLOT_DFS_B);
			5'b0_0100: slot = slot_t'(`SLOT_OS12);
			// split rom/ram bank, mmfs build picks the image
			5'b0_1000: slot = mmfsv1 ? slot_t'(`SLOT_MMFS1_B) : slot_t'(`SLOT_MMFS2_B);
			5'b0_1110: slot = slot_t'(`SLOT_RAMMASTER);
			5'b0_1111: slot = slot_t'(`SLOT_BASIC2);
			// master
			5'b1_0011: slot = mmfsv1 ? slot_t'(`SLOT_MMFS1_M) : slot_t'(`SLOT_MMFS2_M);
			5'b1_0100: slot = slot_t'(`SLOT_MOS);
			// dfs, viewsheet, edit, basic4, adfs, view, terminal
			5'b1_1001, 5'b1_1010, 5'b1_1011, 5'b1_1100,
			5'b1_1101, 5'b1_1110, 5'b1_1111:
				slot = slot_t'(`SLOT_M_DFS) + (bank - bank_t'(9));
			default:   slot = slot_t'(0);
		endcase
	end

	// offset within the bank is untouched
	assign rom_addr = {slot, cpu_addr[13:0]};

	// ==================================================
	// data gating
	// ==================================================

	always_comb begin
		case ({m128, bank})
			5'b0_0100, 5'b0_1110, 5'b0_1111,
			5'b1_0100, 5'b1_1010, 5'b1_1011, 5'b1_1100,
			5'b1_1101, 5'b1_1110, 5'b1_1111:
				rom_data = rom_dout;
			// dfs images
			5'b0_0011, 5'b1_1001:
				rom_data = dfs ? rom_dout : 8'h00;
			// mmfs images, either version
			5'b0_1000, 5'b1_0011:
				rom_data = (mmfsv1 || mmfsv2) ? rom_dout : 8'h00;
			// empty bank reads as zero
			default:
				rom_data = 8'h00;
		endcase
	end

	// menu only offers five filing systems
	a_fs_sel_legal : assert property (@(posedge clk_sys) disable iff (!rst_n)
		fs_sel <= 3'd4)
		else $error("fs_sel out of range: %0d", fs_sel);

endmodule

// File: design/clock_enables.sv
/*
 * single-cycle clock enables at 48, 32 and 24 MHz from the 96 MHz clk_sys
 * consumers qualify their registers with the strobe, no derived clocks
 */
`timescale 1ns/1ps
`include "beeb_cfg.svh"

module clock_enables (
	input  logic clk_sys,
	input  logic rst_n,
	output logic ce_48,
	output logic ce_32,
	output logic ce_24
);

	// ==================================================
	// one wrap-around divider per strobe
	// ==================================================

	for (genvar i = 0; i < 3; i++) begin : g_div
		// 0 -> 48 MHz, 1 -> 32 MHz, 2 -> 24 MHz
		localparam int RATIO = (i == 0) ? `CE48_DIV :
		                       (i == 1) ? `CE32_DIV : `CE24_DIV;

		logic [2:0] cnt;
		logic       strobe;

		always_ff @(posedge clk_sys) begin
			if (!rst_n) begin
				cnt    <= '0;
				strobe <= 1'b0;
			end else begin
				// strobe lands the cycle after the count sits at zero
				strobe <= (cnt == 3'd0);
				if (cnt == 3'(RATIO - 1))
					cnt <= '0;
				else
					cnt <= cnt + 3'd1;
			end
		end
	end

	assign ce_48 = g_div[0].strobe;
	assign ce_32 = g_div[1].strobe;
	assign ce_24 = g_div[2].strobe;

	// half-rate strobe must never merge into a level
	a_ce48_single : assert property (@(posedge clk_sys) disable iff (!rst_n)
		ce_48 |=> !ce_48)
		else $error("ce_48 high on two consecutive cycles");

endmodule

// File: common/beeb_pkg.sv
/*
 * shared types for the board glue
 * imported with a wildcard in each module header that needs them
 */
package beeb_pkg;

	// ==================================================
	// memory map
	// ==================================================

	// 16 KB bank, top four bits of the core address
	typedef logic [3:0] bank_t;

	// physical slot in the 256 KB ROM image
	typedef logic [3:0] slot_t;

	// byte address into the ROM image
	typedef logic [17:0] rom_addr_t;

	// byte address as driven by the core
	typedef logic [17:0] cpu_addr_t;

	// filing system menu choice
	// 0 mmfs v1, 1 mmfs v2, 2 dfs, 3 mmfs v1 + dfs, 4 mmfs v2 + dfs
	typedef logic [2:0] fs_sel_t;

	// ==================================================
	// analog axes
	// ==================================================

	// signed mouse position, wide enough to hold one step past the limits
	typedef logic signed [8:0] axis_t;

	// raw stick axis from the input bridge
	typedef logic [7:0] stick_t;

	// 12-bit unsigned axis as the core's ADC expects
	typedef logic [11:0] core_axis_t;

endpackage

// File: common/beeb_cfg.svh
/*
 * build-time constants for the board glue around the BBC Micro / Master core
 * included by the RTL blocks that need divider ratios, ROM slots or limits
 */
`ifndef BEEB_CFG_SVH
`define BEEB_CFG_SVH

// clock enable ratios against the 96 MHz clk_sys
`define CE48_DIV 2
`define CE32_DIV 3
`define CE24_DIV 4

// model B slots
`define SLOT_OS12      0
`define SLOT_MMFS1_B   1
`define SLOT_RAMMASTER 2
`define SLOT_BASIC2    3
`define SLOT_DFS_B     4
`define SLOT_MMFS2_B   14

// master slots, banks 9..15 run on from SLOT_M_DFS
`define SLOT_MMFS1_M   5
`define SLOT_MOS       6
`define SLOT_M_DFS     7
`define SLOT_MMFS2_M   15

// mouse emulation limits
`define MOUSE_STEP_MAX 10
`define AXIS_MAX       127
`define AXIS_MIN       (-128)

// sd activity stretch, about 20 ms at 96 MHz
`define SD_ACT_HOLD_DEFAULT 2000000

`endif
